/* erx_subsys.f */
common/erx_pkg.sv
erx_cfg/erx_cfg.sv
src/erx_mailbox.sv
src/erx_subsys.sv
bench/erx_props.sv
bench/tb_erx_subsys.sv

/* Makefile */
TOP   = tb_erx_subsys
FLIST = erx_subsys.f

.PHONY: all lint sim clean

all: sim

# rtl only, bench files are parsed but not elaborated
lint:
	verilator --lint-only --timing -f $(FLIST) --top-module erx_subsys

# pass only if the log holds the pass line
sim:
	rm -f sim.log
	verilator --binary --timing --assert -f $(FLIST) --top-module $(TOP)
	-./obj_dir/V$(TOP) | tee sim.log
	grep -qx "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/tb_erx_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_erx_subsys
   import erx_pkg::*;
();

   localparam int n_random = 600;                 // random phase length
   localparam int n_trans  = 660;                 // all cycles incl. reset and directed part

   logic          clk;
   logic          nreset;
   logic          cfg_access;
   emesh_packet_t cfg_packet;
   logic          rx_access;
   emesh_packet_t rx_packet;
   gpio_t         gpio_datain;
   status_t       rx_status;
   logic          rsp_access;
   emesh_packet_t rsp_packet;
   erx_config_t   rx_config;
   idelay_t       idelay_value;
   logic          load_taps;
   logic          mailbox_irq;

   integer seed;

   // reference model state
   data_t   m_cfg      = '0;
   data_t   m_offset   = '0;
   data_t   m_idelay0  = '0;
   data_t   m_idelay1  = '0;                      // only 13 bits live
   data_t   m_testdata = '0;
   gpio_t   m_gpio     = '0;
   status_t m_status   = '0;
   data_t   mbox_q[$];

   logic          exp_rsp       = 1'b0;
   emesh_packet_t exp_pkt       = '0;
   logic          exp_load_taps = 1'b0;

   int pkt_errors   = 0;
   int cfg_errors   = 0;
   int tap_errors   = 0;
   int bit_errors   = 0;
   int proto_errors = 0;

   erx_subsys u_erx_subsys (
      .clk          (clk),
      .nreset       (nreset),
      .cfg_access   (cfg_access),
      .cfg_packet   (cfg_packet),
      .rx_access    (rx_access),
      .rx_packet    (rx_packet),
      .gpio_datain  (gpio_datain),
      .rx_status    (rx_status),
      .rsp_access   (rsp_access),
      .rsp_packet   (rsp_packet),
      .rx_config    (rx_config),
      .idelay_value (idelay_value),
      .load_taps    (load_taps),
      .mailbox_irq  (mailbox_irq)
   );

   bind erx_cfg erx_props u_erx_props (
      .clk        (clk),
      .nreset     (nreset),
      .cfg_access (cfg_access),
      .cfg_packet (cfg_packet),
      .rsp_access (rsp_access),
      .load_taps  (load_taps)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;                     // 100 ns period
   end

   //##########################################################
   // compare tasks
   //##########################################################

   task automatic check_packet(input string name, input emesh_packet_t got,
                               input emesh_packet_t exp);
      if (got !== exp)
      begin
         $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
         pkt_errors++;
      end
   endtask

   task automatic check_config(input string name, input erx_config_t got,
                               input erx_config_t exp);
      if (got !== exp)
      begin
         $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
         cfg_errors++;
      end
   endtask

   task automatic check_idelay(input string name, input idelay_t got, input idelay_t exp);
      if (got !== exp)
      begin
         $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
         tap_errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
         bit_errors++;
      end
   endtask

   //##########################################################
   // model
   //##########################################################

   // cfg bit fields, base from offset
   function automatic erx_config_t make_config(input data_t c, input data_t off);
      erx_config_t x;
      x.test_mode     = c[0];
      x.mmu_enable    = c[1];
      x.remap_mode    = c[3:2];
      x.remap_sel     = c[15:4];
      x.remap_pattern = c[27:16];
      x.remap_base    = off;
      return x;
   endfunction

   // eight data lanes then frame, msb of each lane from idelay1[12:4]
   function automatic idelay_t pack_taps(input data_t d0, input data_t d1);
      idelay_t v;
      v = '0;
      for (int k = 0; k < 8; k++)
      begin
         v[5*k +: 4] = d0[4*k +: 4];
         v[5*k+4]    = d1[4+k];
      end
      v[40 +: 4] = d1[3:0];                       // frame nibble
      v[44]      = d1[12];
      return v;
   endfunction

   task automatic model_apply(input logic acc, input emesh_packet_t req, input logic rxa,
                              input emesh_packet_t rxp, input gpio_t gp, input status_t st);
      logic     mmr;
      logic     is_reg;
      logic     is_mbox;
      logic     is_rr;
      logic     wr;
      reg_idx_t idx;
      data_t    rd;
      mmr     = (req.dstaddr[19:16] == group_mmr) && (req.dstaddr[10:8] == group_rx);
      is_reg  = acc && mmr && !req.dstaddr[5];
      is_mbox = acc && mmr && req.dstaddr[5];
      is_rr   = acc && (req.dstaddr[19:16] == group_rr);
      wr      = req.write;
      idx     = req.dstaddr[7:2];
      rd      = '0;
      // readback sees state before this edge
      if (is_reg && !wr)
      begin
         case (idx)
            reg_cfg:      rd = m_cfg;
            reg_offset:   rd = m_offset;
            reg_idelay0:  rd = m_idelay0;
            reg_idelay1:  rd = m_idelay1;
            reg_testdata: rd = m_testdata;
            reg_gpio:     rd = data_t'(m_gpio);
            reg_status:   rd = data_t'(m_status);
            default:      rd = '0;
         endcase
      end
      else if (is_mbox && !wr)
      begin
         if (mbox_q.size() > 0)
            rd = mbox_q.pop_front();              // empty pop reads zero
      end
      else if (is_mbox && wr)
      begin
         if (mbox_q.size() < mbox_depth)
            mbox_q.push_back(req.data);           // full drops
      end
      exp_rsp          = acc && (!wr || is_rr);
      exp_pkt.write    = 1'b1;
      exp_pkt.datamode = req.datamode;
      exp_pkt.ctrlmode = req.ctrlmode;
      exp_pkt.dstaddr  = is_rr ? req.dstaddr : req.srcaddr;
      exp_pkt.data     = is_rr ? req.data : rd;
      exp_pkt.srcaddr  = req.srcaddr;
      exp_load_taps    = is_reg && wr && (idx == reg_idelay1);
      // register updates
      if (is_reg && wr && idx == reg_cfg)
         m_cfg = req.data;
      if (is_reg && wr && idx == reg_offset)
         m_offset = req.data;
      if (is_reg && wr && idx == reg_idelay0)
         m_idelay0 = req.data;
      if (is_reg && wr && idx == reg_idelay1)
         m_idelay1 = {19'd0, req.data[12:0]};
      if (is_reg && wr && idx == reg_status)
         m_status = req.data[15:0];
      else
         m_status = m_status | st;                // sticky
      if (is_reg && wr && idx == reg_testdata)
         m_testdata = req.data;                   // write wins over rx
      else if (rxa)
         m_testdata = m_testdata + rxp.data;
      m_gpio = gp;
   endtask

   //##########################################################
   // stimulus
   //##########################################################

   task automatic random_packet(output emesh_packet_t p);
      logic [31:0] r;
      r          = $random(seed);
      p.write    = r[0];
      p.datamode = r[2:1];
      p.ctrlmode = r[7:3];
      p.dstaddr  = $random(seed);
      p.data     = $random(seed);
      p.srcaddr  = $random(seed);
   endtask

   // kind 0-2 rx register, 3-4 mailbox, 5 rr, 6 stray address, 7 idle
   task automatic build_request(input logic [2:0] kind, input logic wr,
                                output emesh_packet_t p);
      logic [31:0] r;
      r = $random(seed);
      random_packet(p);
      p.write = wr;
      if (kind <= 3'd4)
      begin
         p.dstaddr[19:16] = group_mmr;
         p.dstaddr[10:8]  = group_rx;
         if (kind >= 3'd3)
            p.dstaddr[7:2] = {r[9:8], 1'b1, r[7:5]};
         else if (r[4])
            p.dstaddr[7:2] = {3'b000, r[7:5]};    // mostly mapped
         else
            p.dstaddr[7:2] = {r[9:8], 1'b0, r[7:5]};
      end
      else if (kind == 3'd5)
         p.dstaddr[19:16] = group_rr;
   endtask

   task automatic check_outputs();
      if (rsp_access && !exp_rsp)
      begin
         $display("response arrived at %0t without a read or readback request", $time);
         proto_errors++;
      end
      else if (!rsp_access && exp_rsp)
      begin
         $display("no response at %0t for a read or readback request", $time);
         proto_errors++;
      end
      else if (exp_rsp)
         check_packet("rsp_packet", rsp_packet, exp_pkt);
      check_bit("load_taps", load_taps, exp_load_taps);
      check_bit("mailbox_irq", mailbox_irq, (mbox_q.size() != 0) && m_cfg[cfg_irq_en_bit]);
      check_config("rx_config", rx_config, make_config(m_cfg, m_offset));
      check_idelay("idelay_value", idelay_value, pack_taps(m_idelay0, m_idelay1));
   endtask

   // drive on the rising edge, check mid cycle, then advance the model
   task automatic run_cycle(input logic acc, input emesh_packet_t req);
      logic [31:0]   r;
      logic [31:0]   s;
      emesh_packet_t rxp;
      @(posedge clk);
      r = $random(seed);
      s = $random(seed);
      random_packet(rxp);
      cfg_access  <= acc;
      cfg_packet  <= req;
      rx_access   <= r[31];
      rx_packet   <= rxp;
      gpio_datain <= r[8:0];
      rx_status   <= r[30:15] & s[15:0] & s[31:16];   // sparse pulses
      @(negedge clk);
      check_outputs();
      model_apply(acc, req, r[31], rxp, r[8:0], r[30:15] & s[15:0] & s[31:16]);
   endtask

   //##########################################################
   // main sequence
   //##########################################################

   initial
   begin
      emesh_packet_t p;
      logic [31:0]   r;
      int            total;
      seed = 99;
      nreset      <= 1'b0;
      cfg_access  <= 1'b0;
      cfg_packet  <= '0;
      rx_access   <= 1'b0;
      rx_packet   <= '0;
      gpio_datain <= '0;
      rx_status   <= '0;
      repeat (8) @(posedge clk);
      nreset <= 1'b1;
      // irq enable on, then overfill and drain the mailbox
      build_request(3'd0, 1'b1, p);
      p.dstaddr[7:2]         = reg_cfg;
      p.data[cfg_irq_en_bit] = 1'b1;
      run_cycle(1'b1, p);
      for (int i = 0; i < 11; i++)
      begin
         build_request(3'd3, 1'b1, p);
         run_cycle(1'b1, p);
      end
      for (int i = 0; i < 11; i++)
      begin
         build_request(3'd3, 1'b0, p);           // last three find it empty
         run_cycle(1'b1, p);
      end
      for (int i = 0; i < n_random; i++)
      begin
         r = $random(seed);
         build_request(r[2:0], r[3], p);
         run_cycle(r[2:0] != 3'd7, p);
      end
      run_cycle(1'b0, p);                         // flush last response
      total = pkt_errors + cfg_errors + tap_errors + bit_errors + proto_errors;
      $display("errors: packet %0d config %0d idelay %0d bit %0d protocol %0d",
               pkt_errors, cfg_errors, tap_errors, bit_errors, proto_errors);
      if (total == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

   // watchdog
   initial
   begin
      #(n_trans * 100 * 4);
      $display("timeout, the stimulus did not finish in time");
      $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* bench/erx_props.sv */
`timescale 1ns/1ps
`default_nettype none

module erx_props
   import erx_pkg::*;
(
   input wire                clk,
   input wire                nreset,
   input wire                cfg_access,
   input wire emesh_packet_t cfg_packet,
   input wire                rsp_access,
   input wire                load_taps
);

   logic rr_req;                                  // readback passthrough
   logic rsp_due;                                 // read or passthrough
   logic tap_wr;                                  // idelay1 write

   assign rr_req  = cfg_access & (cfg_packet.dstaddr[19:16] == group_rr);
   assign rsp_due = (cfg_access & ~cfg_packet.write) | rr_req;
   assign tap_wr  = cfg_access & cfg_packet.write &
                    (cfg_packet.dstaddr[19:16] == group_mmr) &
                    (cfg_packet.dstaddr[10:8] == group_rx) &
                    (cfg_packet.dstaddr[7:2] == reg_idelay1);

   rsp_after_req: assert property (@(posedge clk) disable iff (!nreset) rsp_due |=> rsp_access)
      else $error("request without a response in the next cycle");

   no_rsp_without_req: assert property (@(posedge clk) disable iff (!nreset)
      !rsp_due |=> !rsp_access)
      else $error("response without a request");

   taps_after_write: assert property (@(posedge clk) disable iff (!nreset) tap_wr |=> load_taps)
      else $error("load_taps missing after idelay1 write");

   taps_only_after_write: assert property (@(posedge clk) disable iff (!nreset)
      !tap_wr |=> !load_taps)
      else $error("load_taps without idelay1 write");

endmodule

`default_nettype wire

/* src/erx_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

module erx_subsys
   import erx_pkg::*;
(
   input  wire                clk,
   input  wire                nreset,
   input  wire                cfg_access,
   input  wire emesh_packet_t cfg_packet,
   input  wire                rx_access,
   input  wire emesh_packet_t rx_packet,
   input  wire gpio_t         gpio_datain,
   input  wire status_t       rx_status,
   output logic               rsp_access,
   output emesh_packet_t      rsp_packet,
   output erx_config_t        rx_config,
   output idelay_t            idelay_value,
   output logic               load_taps,
   output logic               mailbox_irq
);

   // cfg <-> mailbox
   logic  mailbox_access;
   logic  mailbox_write;
   data_t mailbox_wdata;
   data_t mailbox_rdata;
   logic  mailbox_irq_en;

   erx_cfg u_erx_cfg (
      .clk            (clk),
      .nreset         (nreset),
      .cfg_access     (cfg_access),
      .cfg_packet     (cfg_packet),
      .rx_access      (rx_access),
      .rx_packet      (rx_packet),
      .gpio_datain    (gpio_datain),
      .rx_status      (rx_status),
      .mailbox_rdata  (mailbox_rdata),
      .mailbox_access (mailbox_access),
      .mailbox_write  (mailbox_write),
      .mailbox_wdata  (mailbox_wdata),
      .mailbox_irq_en (mailbox_irq_en),
      .rsp_access     (rsp_access),
      .rsp_packet     (rsp_packet),
      .rx_config      (rx_config),
      .idelay_value   (idelay_value),
      .load_taps      (load_taps)
   );

   erx_mailbox u_erx_mailbox (
      .clk    (clk),
      .nreset (nreset),
      .access (mailbox_access),
      .write  (mailbox_write),
      .wdata  (mailbox_wdata),
      .irq_en (mailbox_irq_en),
      .rdata  (mailbox_rdata),
      .irq    (mailbox_irq)
   );

endmodule

`default_nettype wire

/* src/erx_mailbox.sv */
`timescale 1ns/1ps
`default_nettype none

module erx_mailbox
   import erx_pkg::*;
(
   input  wire        clk,
   input  wire        nreset,        // async, active low
   input  wire        access,        // decoded mailbox request
   input  wire        write,         // 1 push, 0 pop
   input  wire data_t wdata,
   input  wire        irq_en,
   output data_t      rdata,         // head, valid the cycle after a pop
   output logic       irq
);

   // storage
   data_t mem [mbox_depth];

   // pointers carry one wrap bit above the index
   mbox_ptr_t wr_ptr;
   mbox_ptr_t rd_ptr;
   logic [$bits(mbox_ptr_t)-2:0] wr_idx;
   logic [$bits(mbox_ptr_t)-2:0] rd_idx;

   logic empty;
   logic full;
   logic push;
   logic pop;
   logic pop_valid;                  // pop that actually finds data

   assign wr_idx = wr_ptr[$bits(mbox_ptr_t)-2:0];
   assign rd_idx = rd_ptr[$bits(mbox_ptr_t)-2:0];

   //##########################################################
   // flags
   //##########################################################

   assign empty = (wr_ptr == rd_ptr);
   // same slot, opposite lap
   assign full  = (wr_idx == rd_idx) &
                  (wr_ptr[$bits(mbox_ptr_t)-1] != rd_ptr[$bits(mbox_ptr_t)-1]);

   assign push      = access & write & ~full;        // dropped when full
   assign pop       = access & ~write;
   assign pop_valid = pop & ~empty;

   //##########################################################
   // queue
   //##########################################################

   always_ff @(posedge clk)
   begin
      if (push)
         mem[wr_idx] <= wdata;
   end

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop_valid)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // head out one cycle after the pop, lines up with the cfg response stage
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         rdata <= '0;
      else if (pop_valid)
         rdata <= mem[rd_idx];
      else
         rdata <= '0;                                   // empty pop or idle
   end

   // level irq while anything is waiting
   assign irq = irq_en & ~empty;

endmodule

`default_nettype wire

/* erx_cfg/erx_cfg.sv */
`timescale 1ns/1ps
`default_nettype none

module erx_cfg
   import erx_pkg::*;
(
   input  wire           clk,
   input  wire           nreset,          // async, active low
   // request from tx side
   input  wire           cfg_access,
   input  wire emesh_packet_t cfg_packet,
   // raw rx debug traffic
   input  wire           rx_access,
   input  wire emesh_packet_t rx_packet,
   input  wire gpio_t    gpio_datain,     // static pin levels
   input  wire status_t  rx_status,       // pulses
   // mailbox side
   input  wire data_t    mailbox_rdata,
   output logic          mailbox_access,
   output logic          mailbox_write,
   output data_t         mailbox_wdata,
   output logic          mailbox_irq_en,
   // response
   output logic          rsp_access,
   output emesh_packet_t rsp_packet,
   // rx config out
   output erx_config_t   rx_config,
   output idelay_t       idelay_value,
   output logic          load_taps
);

   addr_t    dstaddr;
   reg_idx_t reg_idx;
   logic     mmr_rx_hit;                  // mmr group + rx subgroup
   logic     reg_hit;
   logic     mbox_hit;
   logic     pass_hit;                    // rr group, passed straight back
   logic     cfg_read;                    // any read that is not a passthrough
   logic     reg_read;
   logic     mbox_read;
   logic     reg_write;
   logic     cfg_wr;
   logic     offset_wr;
   logic     idelay0_wr;
   logic     idelay1_wr;
   logic     testdata_wr;
   logic     status_wr;

   data_t                    cfg_reg;
   data_t                    offset_reg;
   gpio_t                    gpio_reg;
   status_t                  status_reg;
   data_t                    testdata_reg;
   data_t                    idelay0_reg;
   logic [idelay_lanes+3:0]  idelay1_reg;   // frame nibble + nine top bits
   data_t                    reg_rdata;

   // response stage
   data_t     reg_rdata_q;
   data_t     pass_data_q;
   addr_t     rsp_dstaddr_q;
   addr_t     rsp_srcaddr_q;
   datamode_t rsp_datamode_q;
   ctrlmode_t rsp_ctrlmode_q;
   logic      sel_reg_q;
   logic      sel_mbox_q;
   logic      sel_pass_q;
   data_t     rsp_data;

   //##########################################################
   // decode
   //##########################################################

   assign dstaddr = cfg_packet.dstaddr;
   assign reg_idx = dstaddr[7:2];

   assign mmr_rx_hit = (dstaddr[19:16] == group_mmr) & (dstaddr[10:8] == group_rx);
   assign reg_hit    = cfg_access & mmr_rx_hit & ~dstaddr[5];
   assign mbox_hit   = cfg_access & mmr_rx_hit & dstaddr[5];   // upper half is mailbox
   assign pass_hit   = cfg_access & (dstaddr[19:16] == group_rr);

   assign cfg_read  = cfg_access & ~cfg_packet.write & ~pass_hit;
   assign reg_read  = reg_hit & ~cfg_packet.write;
   assign mbox_read = mbox_hit & ~cfg_packet.write;
   assign reg_write = reg_hit & cfg_packet.write;

   // per register write enables
   assign cfg_wr      = reg_write & (reg_idx == reg_cfg);
   assign offset_wr   = reg_write & (reg_idx == reg_offset);
   assign idelay0_wr  = reg_write & (reg_idx == reg_idelay0);
   assign idelay1_wr  = reg_write & (reg_idx == reg_idelay1);
   assign testdata_wr = reg_write & (reg_idx == reg_testdata);
   assign status_wr   = reg_write & (reg_idx == reg_status);

   // mailbox gets the raw request, push/pop chosen by write bit
   assign mailbox_access = mbox_hit;
   assign mailbox_write  = cfg_packet.write;
   assign mailbox_wdata  = cfg_packet.data;

   //##########################################################
   // register file
   //##########################################################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         cfg_reg      <= '0;
         offset_reg   <= '0;
         gpio_reg     <= '0;
         status_reg   <= '0;
         testdata_reg <= '0;
      end
      else
      begin
         if (cfg_wr)
            cfg_reg <= cfg_packet.data;
         if (offset_wr)
            offset_reg <= cfg_packet.data;
         gpio_reg <= gpio_datain;                           // free running sample
         if (status_wr)
            status_reg <= cfg_packet.data[15:0];             // write clears/sets
         else
            status_reg <= status_reg | rx_status;            // sticky
         // write beats accumulate
         if (testdata_wr)
            testdata_reg <= cfg_packet.data;
         else if (rx_access)
            testdata_reg <= testdata_reg + rx_packet.data;
      end
   end

   // static config fields
   always_comb
   begin
      rx_config.test_mode     = cfg_reg[0];
      rx_config.mmu_enable    = cfg_reg[1];
      rx_config.remap_mode    = cfg_reg[3:2];
      rx_config.remap_sel     = cfg_reg[15:4];
      rx_config.remap_pattern = cfg_reg[27:16];
      rx_config.remap_base    = offset_reg;
   end

   assign mailbox_irq_en = cfg_reg[cfg_irq_en_bit];

   //##########################################################
   // idelay taps
   //##########################################################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         idelay0_reg <= '0;
         idelay1_reg <= '0;
         load_taps   <= 1'b0;
      end
      else
      begin
         if (idelay0_wr)
            idelay0_reg <= cfg_packet.data;
         if (idelay1_wr)
            idelay1_reg <= cfg_packet.data[idelay_lanes+3:0];
         load_taps <= idelay1_wr;                            // one pulse, taps now valid
      end
   end

   // five bits per lane: low nibble then msb
   always_comb
   begin
      for (int k = 0; k < idelay_lanes; k++)
      begin
         if (k < idelay_lanes-1)
            idelay_value[k*idelay_tap_w +: 4] = idelay0_reg[4*k +: 4];
         else
            idelay_value[k*idelay_tap_w +: 4] = idelay1_reg[3:0];   // frame lane
         idelay_value[k*idelay_tap_w+4] = idelay1_reg[4+k];
      end
   end

   //##########################################################
   // readback and response
   //##########################################################

   always_comb
   begin
      case (reg_idx)
         reg_cfg:      reg_rdata = cfg_reg;
         reg_offset:   reg_rdata = offset_reg;
         reg_idelay0:  reg_rdata = idelay0_reg;
         reg_idelay1:  reg_rdata = data_t'(idelay1_reg);
         reg_testdata: reg_rdata = testdata_reg;
         reg_gpio:     reg_rdata = data_t'(gpio_reg);
         reg_status:   reg_rdata = data_t'(status_reg);
         default:      reg_rdata = '0;                       // unmapped
      endcase
   end

   // control half of the response stage
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         rsp_access <= 1'b0;
         sel_reg_q  <= 1'b0;
         sel_mbox_q <= 1'b0;
         sel_pass_q <= 1'b0;
      end
      else
      begin
         rsp_access <= cfg_read | pass_hit;
         sel_reg_q  <= reg_read;
         sel_mbox_q <= mbox_read;                            // mailbox registers its head too
         sel_pass_q <= pass_hit;
      end
   end

   // payload half
   always_ff @(posedge clk)
   begin
      if (reg_read)
         reg_rdata_q <= reg_rdata;
      pass_data_q    <= cfg_packet.data;
      rsp_dstaddr_q  <= pass_hit ? dstaddr : cfg_packet.srcaddr;   // reads return to sender
      rsp_srcaddr_q  <= cfg_packet.srcaddr;
      rsp_datamode_q <= cfg_packet.datamode;
      rsp_ctrlmode_q <= cfg_packet.ctrlmode;
   end

   // one-hot or mux, nothing selected reads zero
   assign rsp_data = ({aw{sel_reg_q}}  & reg_rdata_q)   |
                     ({aw{sel_mbox_q}} & mailbox_rdata) |
                     ({aw{sel_pass_q}} & pass_data_q);

   always_comb
   begin
      rsp_packet.write    = 1'b1;                            // responses always write back
      rsp_packet.datamode = rsp_datamode_q;
      rsp_packet.ctrlmode = rsp_ctrlmode_q;
      rsp_packet.dstaddr  = rsp_dstaddr_q;
      rsp_packet.data     = rsp_data;
      rsp_packet.srcaddr  = rsp_srcaddr_q;
   end

endmodule

`default_nettype wire

/* common/erx_pkg.sv */
`default_nettype none

package erx_pkg;

   //##########################################################
   // emesh packet
   //##########################################################

   localparam int aw = 32;                     // address and data width

   typedef logic [aw-1:0] addr_t;              // emesh address
   typedef logic [aw-1:0] data_t;              // emesh data word
   typedef logic [4:0]    ctrlmode_t;          // routing / special modes
   typedef logic [1:0]    datamode_t;          // 8/16/32/64 bit transfer size

   // 104 bits, write bit on top, srcaddr at the bottom
   typedef struct packed {
      logic      write;
      datamode_t datamode;
      ctrlmode_t ctrlmode;
      addr_t     dstaddr;
      data_t     data;
      addr_t     srcaddr;
   } emesh_packet_t;

   //##########################################################
   // address map
   //##########################################################

   localparam logic [3:0] group_mmr = 4'hf;    // dstaddr[19:16]
   localparam logic [2:0] group_rx  = 3'h1;    // dstaddr[10:8], rx block
   localparam logic [3:0] group_rr  = 4'he;    // readback from tx side, dstaddr[19:16]

   // register index, dstaddr[7:2]
   typedef logic [5:0] reg_idx_t;

   localparam reg_idx_t reg_cfg      = 6'd0;
   localparam reg_idx_t reg_offset   = 6'd1;   // dynamic remap base
   localparam reg_idx_t reg_idelay0  = 6'd2;   // low tap nibbles d0..d7
   localparam reg_idx_t reg_idelay1  = 6'd3;   // frame nibble + top bits
   localparam reg_idx_t reg_testdata = 6'd4;
   localparam reg_idx_t reg_gpio     = 6'd5;
   localparam reg_idx_t reg_status   = 6'd6;

   localparam int cfg_irq_en_bit = 28;         // mailbox irq enable in cfg

   //##########################################################
   // rx io side
   //##########################################################

   localparam int idelay_lanes = 9;            // eight data lanes, frame last
   localparam int idelay_tap_w = 5;

   typedef logic [idelay_lanes-1:0] gpio_t;    // frame and data pins
   typedef logic [15:0]             status_t;
   typedef logic [idelay_lanes*idelay_tap_w-1:0] idelay_t;

   // static rx config, decoded from cfg and offset
   typedef struct packed {
      logic        test_mode;
      logic        mmu_enable;
      logic [1:0]  remap_mode;
      logic [11:0] remap_sel;
      logic [11:0] remap_pattern;
      addr_t       remap_base;
   } erx_config_t;

   // mailbox
   localparam int mbox_depth = 8;
   typedef logic [$clog2(mbox_depth):0] mbox_ptr_t;   // extra wrap bit

endpackage

`default_nettype wire
